// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module store_unit_tb -f vlog.f

out=$(./obj_dir/Vstore_unit_tb)
echo "$out"

if echo "$out" | grep -qx ">>> PASS"; then
    exit 0
else
    exit 1
fi

// File: sq_alloc.sv
`timescale 1ns/1ps

module sq_alloc #(
    parameter  int DEPTH     = 8,
    localparam int DEPTH_LOG = $clog2(DEPTH)
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 enq_valid,
    input  logic                 flush_valid,
    input  logic [DEPTH-1:0]     slot_valid,
    input  logic [DEPTH-1:0]     kill_vec,
    output logic                 can_alloc,
    output logic                 alloc_fire,
    output logic [DEPTH_LOG-1:0] alloc_slot,
    output logic [DEPTH_LOG-1:0] enq_sq_idx,
    output logic                 enq_sq_flag
);

    // slot index plus wrap bit on top
    logic [DEPTH_LOG:0] enq_ptr;
    // number of entries removed by the current flush
    logic [DEPTH_LOG:0] kill_cnt;

    always_comb begin
        kill_cnt = '0;
        for (int i = 0; i < DEPTH; i++) begin
            kill_cnt = kill_cnt + {{DEPTH_LOG{1'b0}}, kill_vec[i]};
        end
    end

    assign alloc_slot = enq_ptr[DEPTH_LOG-1:0];

    // no allocation while a flush is rolling the pointer back
    assign can_alloc  = !slot_valid[alloc_slot] && !flush_valid;
    assign alloc_fire = enq_valid && can_alloc;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
        end else if (flush_valid) begin
            // killed stores are always the youngest, so they sit right below the pointer;
            // the subtraction wraps modulo 2*DEPTH and fixes the flag as well
            enq_ptr <= enq_ptr - kill_cnt;
        end else if (alloc_fire) begin
            enq_ptr <= enq_ptr + 1'b1;
        end
    end

    assign enq_sq_idx  = enq_ptr[DEPTH_LOG-1:0];
    assign enq_sq_flag = enq_ptr[DEPTH_LOG];

endmodule

// File: sq_drain.sv
`timescale 1ns/1ps

module sq_drain #(
    parameter  int DEPTH     = 8,
    localparam int DEPTH_LOG = $clog2(DEPTH)
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      head_valid,
    input  logic                      head_ready,
    input  logic                      head_mmio,
    input  logic [sq_pkg::addr_w-1:0] head_addr,
    input  logic [sq_pkg::data_w-1:0] head_data,
    input  logic [sq_pkg::mask_w-1:0] head_mask,
    input  logic                      mem_req_ready,
    output logic [DEPTH_LOG-1:0]      head_slot,
    output logic                      retire_fire,
    output logic                      mem_req_valid,
    output logic [sq_pkg::addr_w-1:0] mem_req_addr,
    output logic [sq_pkg::data_w-1:0] mem_req_data,
    output logic [sq_pkg::mask_w-1:0] mem_req_mask
);

    logic [DEPTH_LOG-1:0] deq_ptr;
    // head store is committed and written back
    logic                 head_go;
    // ready mmio store leaves without a cache request
    logic                 mmio_skip;
    logic                 mem_fire;

    assign head_go   = head_valid && head_ready;
    assign mmio_skip = head_go && head_mmio;

    assign mem_req_valid = head_go && !head_mmio;
    assign mem_fire      = mem_req_valid && mem_req_ready;
    assign retire_fire   = mem_fire || mmio_skip;

    // payload comes straight from the head entry, held there until retire
    assign mem_req_addr = head_addr;
    assign mem_req_data = head_data;
    assign mem_req_mask = head_mask;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            deq_ptr <= '0;
        end else if (retire_fire) begin
            deq_ptr <= deq_ptr + 1'b1;
        end
    end

    assign head_slot = deq_ptr;

endmodule

// File: sq_entry.sv
`timescale 1ns/1ps

module sq_entry (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         alloc,
    input  logic                         alloc_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] alloc_rob_idx,
    input  logic                         wb_set,
    input  logic                         wb_mmio,
    input  logic [sq_pkg::addr_w-1:0]    wb_addr,
    input  logic [sq_pkg::data_w-1:0]    wb_data,
    input  logic [sq_pkg::mask_w-1:0]    wb_mask,
    input  logic                         commit,
    input  logic                         kill,
    input  logic                         retire,
    output logic                         valid,
    output logic                         rob_flag,
    output logic [sq_pkg::rob_idx_w-1:0] rob_idx,
    output logic                         mmio,
    output logic                         ready,
    output logic [sq_pkg::addr_w-1:0]    addr,
    output logic [sq_pkg::data_w-1:0]    data,
    output logic [sq_pkg::mask_w-1:0]    mask
);

    // payload from writeback has arrived
    logic written;
    // store has retired from the ROB
    logic committed;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid     <= 1'b0;
            written   <= 1'b0;
            committed <= 1'b0;
        end else if (alloc) begin
            // fresh store, nothing known beyond its rob tag yet
            valid     <= 1'b1;
            written   <= 1'b0;
            committed <= 1'b0;
        end else if (kill || retire) begin
            valid     <= 1'b0;
            written   <= 1'b0;
            committed <= 1'b0;
        end else begin
            if (wb_set) begin
                written <= 1'b1;
            end
            if (commit) begin
                committed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            rob_flag <= alloc_rob_flag;
            rob_idx  <= alloc_rob_idx;
        end
        if (wb_set) begin
            mmio <= wb_mmio;
            addr <= wb_addr;
            data <= wb_data;
            mask <= wb_mask;
        end
    end

    // eligible to drain once both halves are in
    assign ready = committed & written;

endmodule

// File: sq_pkg.sv
package sq_pkg;

    // reorder-buffer index width, the wrap flag is carried as a separate bit
    localparam int rob_idx_w = 6;

    // store payload widths
    localparam int addr_w = 32;
    localparam int data_w = 64;
    // one mask bit per data byte
    localparam int mask_w = data_w / 8;

    // true when (a_flag, a_idx) is strictly younger than (b_flag, b_idx)
    function automatic logic rob_younger(
        input logic                 a_flag,
        input logic [rob_idx_w-1:0] a_idx,
        input logic                 b_flag,
        input logic [rob_idx_w-1:0] b_idx
    );
        logic flag_differ;
        logic idx_greater;
        flag_differ = a_flag ^ b_flag;
        idx_greater = a_idx > b_idx;
        // crossing the wrap point inverts the plain index order
        return flag_differ ^ idx_greater;
    endfunction

    // exact match of two reorder-buffer tags including the wrap flag
    function automatic logic rob_match(
        input logic                 a_flag,
        input logic [rob_idx_w-1:0] a_idx,
        input logic                 b_flag,
        input logic [rob_idx_w-1:0] b_idx
    );
        return (a_flag == b_flag) && (a_idx == b_idx);
    endfunction

endpackage

// File: store_queue.sv
`timescale 1ns/1ps

module store_queue #(
    parameter  int DEPTH     = 8,
    localparam int DEPTH_LOG = $clog2(DEPTH)
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         alloc_fire,
    input  logic [DEPTH_LOG-1:0]         alloc_slot,
    input  logic                         enq_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] enq_rob_idx,
    input  logic                         wb_valid,
    input  logic                         wb_mmio,
    input  logic                         wb_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] wb_rob_idx,
    input  logic [sq_pkg::addr_w-1:0]    wb_addr,
    input  logic [sq_pkg::data_w-1:0]    wb_data,
    input  logic [sq_pkg::mask_w-1:0]    wb_mask,
    input  logic                         commit0_valid,
    input  logic                         commit0_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] commit0_rob_idx,
    input  logic                         commit1_valid,
    input  logic                         commit1_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] commit1_rob_idx,
    input  logic                         flush_valid,
    input  logic                         flush_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] flush_rob_idx,
    input  logic [DEPTH_LOG-1:0]         head_slot,
    input  logic                         retire_fire,
    output logic [DEPTH-1:0]             slot_valid,
    output logic [DEPTH-1:0]             kill_vec,
    output logic                         head_valid,
    output logic                         head_ready,
    output logic                         head_mmio,
    output logic [sq_pkg::addr_w-1:0]    head_addr,
    output logic [sq_pkg::data_w-1:0]    head_data,
    output logic [sq_pkg::mask_w-1:0]    head_mask
);

    // one-hot strobes per entry
    logic [DEPTH-1:0] alloc_vec;
    logic [DEPTH-1:0] wb_vec;
    logic [DEPTH-1:0] commit_vec;
    logic [DEPTH-1:0] retire_vec;

    // per-entry state seen from outside the entry
    logic [DEPTH-1:0] entry_rob_flag;
    logic [DEPTH-1:0] entry_mmio;
    logic [DEPTH-1:0] entry_ready;

    logic [sq_pkg::rob_idx_w-1:0] entry_rob_idx [DEPTH];
    logic [sq_pkg::addr_w-1:0]    entry_addr    [DEPTH];
    logic [sq_pkg::data_w-1:0]    entry_data    [DEPTH];
    logic [sq_pkg::mask_w-1:0]    entry_mask    [DEPTH];

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            alloc_vec[i]  = alloc_fire && (alloc_slot == DEPTH_LOG'(i));
            retire_vec[i] = retire_fire && (head_slot == DEPTH_LOG'(i));

            // only live entries can match a rob tag
            wb_vec[i] = wb_valid && slot_valid[i]
                && sq_pkg::rob_match(wb_rob_flag, wb_rob_idx,
                                     entry_rob_flag[i], entry_rob_idx[i]);

            commit_vec[i] = slot_valid[i]
                && ((commit0_valid
                     && sq_pkg::rob_match(commit0_rob_flag, commit0_rob_idx,
                                          entry_rob_flag[i], entry_rob_idx[i]))
                 || (commit1_valid
                     && sq_pkg::rob_match(commit1_rob_flag, commit1_rob_idx,
                                          entry_rob_flag[i], entry_rob_idx[i])));

            // a committed store still waiting for writeback is older than any
            // redirect, so the ready bit is enough to protect committed entries
            kill_vec[i] = flush_valid && slot_valid[i] && !entry_ready[i]
                && sq_pkg::rob_younger(entry_rob_flag[i], entry_rob_idx[i],
                                       flush_rob_flag, flush_rob_idx);
        end
    end

    for (genvar g = 0; g < DEPTH; g++) begin : g_entry
        sq_entry u_entry (
            .clock          (clock),
            .reset_n        (reset_n),
            .alloc          (alloc_vec[g]),
            .alloc_rob_flag (enq_rob_flag),
            .alloc_rob_idx  (enq_rob_idx),
            .wb_set         (wb_vec[g]),
            .wb_mmio        (wb_mmio),
            .wb_addr        (wb_addr),
            .wb_data        (wb_data),
            .wb_mask        (wb_mask),
            .commit         (commit_vec[g]),
            .kill           (kill_vec[g]),
            .retire         (retire_vec[g]),
            .valid          (slot_valid[g]),
            .rob_flag       (entry_rob_flag[g]),
            .rob_idx        (entry_rob_idx[g]),
            .mmio           (entry_mmio[g]),
            .ready          (entry_ready[g]),
            .addr           (entry_addr[g]),
            .data           (entry_data[g]),
            .mask           (entry_mask[g])
        );
    end

    // head view for the drain side
    assign head_valid = slot_valid[head_slot];
    assign head_ready = entry_ready[head_slot];
    assign head_mmio  = entry_mmio[head_slot];
    assign head_addr  = entry_addr[head_slot];
    assign head_data  = entry_data[head_slot];
    assign head_mask  = entry_mask[head_slot];

endmodule

// File: store_unit_chk.sv
`timescale 1ns/1ps

module store_unit_chk (
    input logic                      clock,
    input logic                      reset_n,
    input logic                      mem_req_valid,
    input logic                      mem_req_ready,
    input logic [sq_pkg::addr_w-1:0] mem_req_addr,
    input logic [sq_pkg::data_w-1:0] mem_req_data,
    input logic [sq_pkg::mask_w-1:0] mem_req_mask,
    input logic                      can_alloc,
    input logic                      flush_valid
);

    // no write request may leave while the unit is in reset
    a_reset_idle: assert property (@(posedge clock) !reset_n |-> !mem_req_valid)
        else $error("write request raised during reset");

    // a stalled request holds its valid and payload
    a_req_hold: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid
            && $stable(mem_req_addr) && $stable(mem_req_data) && $stable(mem_req_mask))
        else $error("write request dropped or changed under back-pressure");

    a_flush_block: assert property (@(posedge clock) disable iff (!reset_n)
        flush_valid |-> !can_alloc)
        else $error("allocation allowed during flush");

endmodule

bind store_unit_top store_unit_chk chk0 (
    .clock         (clock),
    .reset_n       (reset_n),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .mem_req_mask  (mem_req_mask),
    .can_alloc     (can_alloc),
    .flush_valid   (flush_valid)
);

// File: store_unit_tb.sv
`timescale 1ns/1ps

module store_unit_tb;

    localparam int ROWS = 32;
    localparam int GROUPS = 6;

    logic        clock;
    logic        reset_n;
    logic        enq_valid, enq_rob_flag, can_alloc, enq_sq_flag;
    logic [5:0]  enq_rob_idx;
    logic [2:0]  enq_sq_idx;
    logic        wb_valid, wb_mmio, wb_rob_flag;
    logic [5:0]  wb_rob_idx;
    logic [31:0] wb_addr;
    logic [63:0] wb_data;
    logic [7:0]  wb_mask;
    logic        commit0_valid, commit0_rob_flag, commit1_valid, commit1_rob_flag;
    logic [5:0]  commit0_rob_idx, commit1_rob_idx;
    logic        flush_valid, flush_rob_flag;
    logic [5:0]  flush_rob_idx;
    logic        mem_req_valid, mem_req_ready;
    logic [31:0] mem_req_addr;
    logic [63:0] mem_req_data;
    logic [7:0]  mem_req_mask;

    // the row number doubles as the rob index
    logic [31:0] t_addr [ROWS];
    logic [63:0] t_data [ROWS];
    logic [7:0]  t_mask [ROWS];
    logic        t_mmio [ROWS];
    // per group the first row, row count, flush row (-1 for none), hold and ready mode
    int g_first [GROUPS] = '{0, 4, 8, 16, 24, 29};
    int g_cnt   [GROUPS] = '{4, 4, 8, 8, 5, 3};
    int g_flush [GROUPS] = '{-1, -1, -1, -1, 25, -1};
    int g_hold  [GROUPS] = '{0, 0, 1, 0, 0, 0};
    int g_mode  [GROUPS] = '{1, 1, 0, 2, 1, 2};

    // expected writes in drain order
    logic [31:0] exp_addr [$];
    logic [63:0] exp_data [$];
    logic [7:0]  exp_mask [$];
    logic [3:0]  sq_ptr;
    int          exp_total;
    int          write_count;
    // 0 holds ready low, 1 holds it high, 2 randomizes it
    int          ready_mode;

    tb_clock_gen clk0 (.clock(clock), .reset_n(reset_n));

    store_unit_top #(.DEPTH(8)) dut0 (.*);

    task automatic check_value(string what, logic [63:0] got, logic [63:0] expected);
        if (got !== expected) begin
            $display("ERROR %0t ns: %s: got %0h, expected %0h", $time, what, got, expected);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic stop_on_timeout(string what);
        $display("timed out waiting for %s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    always @(posedge clock) begin
        if (ready_mode == 2) begin
            mem_req_ready <= 1'($urandom % 2);
        end else begin
            mem_req_ready <= (ready_mode == 1);
        end
    end

    // a request seen at the falling edge transfers at the next rising edge
    always @(negedge clock) begin
        if (reset_n && mem_req_valid && mem_req_ready) begin
            if (exp_addr.size() == 0) begin
                $display("memory write seen with no store expected");
                $display(">>> FAIL");
                $fatal(1);
            end
            check_value("write addr", 64'(mem_req_addr), 64'(exp_addr[0]));
            check_value("write data", mem_req_data, exp_data[0]);
            check_value("write mask", 64'(mem_req_mask), 64'(exp_mask[0]));
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            void'(exp_mask.pop_front());
            write_count++;
        end
    end

    task automatic enqueue_store(int row);
        int n;
        n = 0;
        @(negedge clock);
        while (!can_alloc) begin
            n++;
            if (n > 200) stop_on_timeout("a free store queue slot");
            @(negedge clock);
        end
        check_value("enq_sq_idx", 64'(enq_sq_idx), 64'(sq_ptr[2:0]));
        check_value("enq_sq_flag", 64'(enq_sq_flag), 64'(sq_ptr[3]));
        @(posedge clock);
        enq_valid   <= 1'b1;
        enq_rob_idx <= 6'(row);
        @(posedge clock);
        enq_valid <= 1'b0;
        sq_ptr = sq_ptr + 4'd1;
    endtask

    task automatic writeback_store(int row);
        @(posedge clock);
        wb_valid   <= 1'b1;
        wb_rob_idx <= 6'(row);
        wb_mmio    <= t_mmio[row];
        wb_addr    <= t_addr[row];
        wb_data    <= t_data[row];
        wb_mask    <= t_mask[row];
        @(posedge clock);
        wb_valid <= 1'b0;
    endtask

    task automatic commit_stores(int row0, int row1, logic both);
        @(posedge clock);
        commit0_valid   <= 1'b1;
        commit0_rob_idx <= 6'(row0);
        commit1_valid   <= both;
        commit1_rob_idx <= 6'(row1);
        @(posedge clock);
        commit0_valid <= 1'b0;
        commit1_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clock);
        while (exp_addr.size() != 0) begin
            n++;
            if (n > 2000) stop_on_timeout("the queue to drain");
            @(negedge clock);
        end
    endtask

    task automatic run_group(int first, int cnt, int flush_row, int hold);
        int live;
        int start;
        int n;
        live = cnt;
        start = 0;
        for (int i = 0; i < cnt; i++) enqueue_store(first + i);
        if (flush_row >= 0) begin
            @(posedge clock);
            flush_valid   <= 1'b1;
            flush_rob_idx <= 6'(flush_row);
            @(posedge clock);
            flush_valid <= 1'b0;
            // stores younger than the flush row are dropped
            sq_ptr = sq_ptr - 4'(first + cnt - 1 - flush_row);
            live = flush_row - first + 1;
            @(negedge clock);
            check_value("enq_sq_idx after flush", 64'(enq_sq_idx), 64'(sq_ptr[2:0]));
        end
        if (hold) begin
            @(negedge clock);
            check_value("can_alloc when full", 64'(can_alloc), 64'd0);
        end
        for (int i = live - 1; i >= 0; i--) writeback_store(first + i);
        for (int i = 0; i < live; i++) begin
            if (!t_mmio[first + i]) begin
                exp_addr.push_back(t_addr[first + i]);
                exp_data.push_back(t_data[first + i]);
                exp_mask.push_back(t_mask[first + i]);
            end
        end
        if (hold) begin
            commit_stores(first, first, 1'b0);
            @(negedge clock);
            ready_mode = 1;
            n = 0;
            while (exp_addr.size() != cnt - 1) begin
                n++;
                if (n > 200) stop_on_timeout("the first write after the stall");
                @(negedge clock);
            end
            @(negedge clock);
            check_value("can_alloc after one write", 64'(can_alloc), 64'd1);
            start = 1;
        end
        for (int i = start; i < live; i += 2) begin
            commit_stores(first + i, first + i + 1, (i + 1 < live));
        end
        wait_drain();
    endtask

    initial begin
        int n;
        enq_valid <= 1'b0;
        enq_rob_flag <= 1'b0;
        enq_rob_idx <= '0;
        wb_valid <= 1'b0;
        wb_mmio <= 1'b0;
        wb_rob_flag <= 1'b0;
        wb_rob_idx <= '0;
        wb_addr <= '0;
        wb_data <= '0;
        wb_mask <= '0;
        commit0_valid <= 1'b0;
        commit0_rob_flag <= 1'b0;
        commit0_rob_idx <= '0;
        commit1_valid <= 1'b0;
        commit1_rob_flag <= 1'b0;
        commit1_rob_idx <= '0;
        flush_valid <= 1'b0;
        flush_rob_flag <= 1'b0;
        flush_rob_idx <= '0;
        mem_req_ready <= 1'b0;
        ready_mode = 1;
        sq_ptr = '0;
        exp_total = 0;
        write_count = 0;
        void'($urandom(42));
        for (int i = 0; i < ROWS; i++) begin
            t_addr[i] = 32'h8000_0000 + 32'(i * 8);
            t_data[i] = {$urandom, $urandom};
            t_mask[i] = 8'($urandom);
            t_mmio[i] = 1'b0;
        end
        // hand-picked rows for the ordered and MMIO cases
        t_addr[0] = 32'h0000_1000;
        t_data[0] = 64'h1111_2222_3333_4444;
        t_mask[0] = 8'hff;
        t_addr[1] = 32'h0000_1008;
        t_data[1] = 64'h0000_0000_dead_beef;
        t_mask[1] = 8'h0f;
        t_addr[5] = 32'h4000_0000;
        t_mmio[5] = 1'b1;
        t_addr[6] = 32'h4000_0004;
        t_mmio[6] = 1'b1;
        // every committed store that survives its flush and is not MMIO makes one write
        for (int g = 0; g < GROUPS; g++) begin
            for (int i = 0; i < g_cnt[g]; i++) begin
                if (!t_mmio[g_first[g] + i]
                    && (g_flush[g] < 0 || g_first[g] + i <= g_flush[g])) begin
                    exp_total++;
                end
            end
        end
        n = 0;
        while (!reset_n) begin
            n++;
            if (n > 100) stop_on_timeout("reset release");
            @(negedge clock);
        end
        @(negedge clock);
        check_value("can_alloc after reset", 64'(can_alloc), 64'd1);
        check_value("mem_req_valid after reset", 64'(mem_req_valid), 64'd0);
        check_value("enq_sq_idx after reset", 64'(enq_sq_idx), 64'd0);
        check_value("enq_sq_flag after reset", 64'(enq_sq_flag), 64'd0);
        for (int g = 0; g < GROUPS; g++) begin
            ready_mode = g_mode[g];
            run_group(g_first[g], g_cnt[g], g_flush[g], g_hold[g]);
        end
        check_value("write count", 64'(write_count), 64'(exp_total));
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: store_unit_top.sv
`timescale 1ns/1ps

// DEPTH has to be a power of two, the pointers wrap by overflow
module store_unit_top #(
    parameter  int DEPTH     = 8,
    localparam int DEPTH_LOG = $clog2(DEPTH)
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         enq_valid,
    input  logic                         enq_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] enq_rob_idx,
    output logic                         can_alloc,
    output logic                         enq_sq_flag,
    output logic [DEPTH_LOG-1:0]         enq_sq_idx,
    input  logic                         wb_valid,
    input  logic                         wb_mmio,
    input  logic                         wb_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] wb_rob_idx,
    input  logic [sq_pkg::addr_w-1:0]    wb_addr,
    input  logic [sq_pkg::data_w-1:0]    wb_data,
    input  logic [sq_pkg::mask_w-1:0]    wb_mask,
    input  logic                         commit0_valid,
    input  logic                         commit0_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] commit0_rob_idx,
    input  logic                         commit1_valid,
    input  logic                         commit1_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] commit1_rob_idx,
    input  logic                         flush_valid,
    input  logic                         flush_rob_flag,
    input  logic [sq_pkg::rob_idx_w-1:0] flush_rob_idx,
    output logic                         mem_req_valid,
    output logic [sq_pkg::addr_w-1:0]    mem_req_addr,
    output logic [sq_pkg::data_w-1:0]    mem_req_data,
    output logic [sq_pkg::mask_w-1:0]    mem_req_mask,
    input  logic                         mem_req_ready
);

    // allocation side to entry array
    logic                      alloc_fire;
    logic [DEPTH_LOG-1:0]      alloc_slot;
    logic [DEPTH-1:0]          slot_valid;
    logic [DEPTH-1:0]          kill_vec;

    // entry array to drain side
    logic [DEPTH_LOG-1:0]      head_slot;
    logic                      retire_fire;
    logic                      head_valid;
    logic                      head_ready;
    logic                      head_mmio;
    logic [sq_pkg::addr_w-1:0] head_addr;
    logic [sq_pkg::data_w-1:0] head_data;
    logic [sq_pkg::mask_w-1:0] head_mask;

    // port names line up with the nets above
    sq_alloc #(.DEPTH(DEPTH)) u_alloc (.*);

    store_queue #(.DEPTH(DEPTH)) u_queue (.*);

    sq_drain #(.DEPTH(DEPTH)) u_drain (.*);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // reset held for the first 16 rising edges
    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

// File: vlog.f
sq_pkg.sv
sq_entry.sv
sq_alloc.sv
sq_drain.sv
store_queue.sv
store_unit_top.sv
tb_clock_gen.sv
store_unit_chk.sv
store_unit_tb.sv
